// File: common/hazard_if.sv
`timescale 1ns/1ps

interface hazard_if;

    // Hazard unit outputs
    logic               stall_front;
    logic               flush_if2id;
    logic               flush_id2exe;
    logic               redirect;
    pipe_pkg::fwd_sel_e fwd_rs1;
    pipe_pkg::fwd_sel_e fwd_rs2;

    // Register numbers and status from the stages
    isa_pkg::reg_idx_t  id_rs1;
    isa_pkg::reg_idx_t  id_rs2;
    isa_pkg::reg_idx_t  exe_rd;
    isa_pkg::reg_idx_t  exe_rs1;
    isa_pkg::reg_idx_t  exe_rs2;
    logic               exe_is_load;
    logic               exe_taken;
    isa_pkg::reg_idx_t  lsu_rd;
    logic               lsu_we;
    isa_pkg::reg_idx_t  wrb_rd;
    logic               wrb_we;

    modport fwd (
        input  id_rs1, id_rs2, exe_rd, exe_rs1, exe_rs2, exe_is_load, exe_taken,
        input  lsu_rd, lsu_we, wrb_rd, wrb_we,
        output stall_front, flush_if2id, flush_id2exe, redirect, fwd_rs1, fwd_rs2
    );

    modport fetch_mp (input stall_front, flush_if2id, redirect);

    modport decode_mp (input stall_front, flush_id2exe, output id_rs1, id_rs2);

    modport execute_mp (
        input  fwd_rs1, fwd_rs2,
        output exe_rd, exe_rs1, exe_rs2, exe_is_load, exe_taken
    );

    modport lsu_mp (output lsu_rd, lsu_we, wrb_rd, wrb_we);

endinterface : hazard_if

// File: common/isa_pkg.sv
package isa_pkg;

    // Datapath width
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [XLEN-1:0] addr_t;
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [6:0]      funct7_t;

    // Major opcodes of the supported RV32I subset
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;

    // funct3 values for register and immediate ALU ops
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // Word-sized load and store
    localparam funct3_t F3_WORD = 3'b010;

    // Branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;

    // funct7 that turns ADD into SUB
    localparam funct7_t F7_SUB  = 7'b0100000;

    // addi x0, x0, 0
    localparam instr_t INSTR_NOP = 32'h0000_0013;

endpackage : isa_pkg

// File: common/pipe_pkg.sv
package pipe_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_e;

    // Operand source chosen by the hazard unit
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_LSU,
        FWD_WRB
    } fwd_sel_e;

    typedef struct packed {
        logic            valid;
        isa_pkg::addr_t  pc;
        isa_pkg::instr_t instr;
    } if2id_t;

    typedef struct packed {
        logic              valid;
        isa_pkg::addr_t    pc;
        isa_pkg::reg_idx_t rs1;
        isa_pkg::reg_idx_t rs2;
        isa_pkg::reg_idx_t rd;
        isa_pkg::word_t    rs1_data;
        isa_pkg::word_t    rs2_data;
        isa_pkg::word_t    imm;
        alu_op_e           alu_op;
        logic              use_imm;
        logic              reg_we;
        wb_sel_e           wb_sel;
        logic              is_load;
        logic              is_store;
        logic              is_branch;
        logic              branch_ne;
        logic              is_jal;
    } id2exe_t;

    typedef struct packed {
        logic              valid;
        isa_pkg::reg_idx_t rd;
        logic              reg_we;
        wb_sel_e           wb_sel;
        logic              is_load;
        logic              is_store;
        isa_pkg::word_t    alu_result;
        isa_pkg::word_t    store_data;
        isa_pkg::addr_t    pc4;
    } exe2lsu_t;

    // Register file write, also used for forwarding
    typedef struct packed {
        logic              we;
        isa_pkg::reg_idx_t rd;
        isa_pkg::word_t    data;
    } wrb_t;

    typedef struct packed {
        logic           taken;
        isa_pkg::addr_t target;
    } redirect_t;

endpackage : pipe_pkg

// File: decode/decode.sv
`timescale 1ns/1ps

module decode (
    input  logic              clk,
    input  logic              rst_n,
    input  pipe_pkg::if2id_t  if2id_i,
    input  pipe_pkg::wrb_t    wrb_i,
    hazard_if.decode_mp       hz,
    output pipe_pkg::id2exe_t id2exe_o
);

    isa_pkg::word_t    rf [32];
    isa_pkg::instr_t   instr;
    isa_pkg::opcode_t  opcode;
    isa_pkg::funct3_t  funct3;
    isa_pkg::funct7_t  funct7;
    isa_pkg::reg_idx_t rs1;
    isa_pkg::reg_idx_t rs2;
    isa_pkg::reg_idx_t rd;
    pipe_pkg::id2exe_t id_next;
    pipe_pkg::id2exe_t id2exe_q;

    assign instr  = if2id_i.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    // Write-first read with x0 hardwired to zero
    function automatic isa_pkg::word_t rf_read(input isa_pkg::reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wrb_i.we && wrb_i.rd == idx) begin
            return wrb_i.data;
        end
        return rf[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (wrb_i.we && wrb_i.rd != '0) begin
            rf[wrb_i.rd] <= wrb_i.data;
        end
    end

    always_comb begin
        id_next          = '0;
        id_next.valid    = if2id_i.valid;
        id_next.pc       = if2id_i.pc;
        id_next.rs1      = rs1;
        id_next.rs2      = rs2;
        id_next.rd       = rd;
        id_next.rs1_data = rf_read(rs1);
        id_next.rs2_data = rf_read(rs2);
        id_next.alu_op   = pipe_pkg::ALU_ADD;
        id_next.wb_sel   = pipe_pkg::WB_ALU;
        // Unsupported encodings leave every control low
        if (if2id_i.valid) begin
            case (opcode)
                isa_pkg::OPC_OP: begin
                    id_next.reg_we = 1'b1;
                    case (funct3)
                        isa_pkg::F3_ADD: id_next.alu_op = (funct7 == isa_pkg::F7_SUB) ?
                                                          pipe_pkg::ALU_SUB : pipe_pkg::ALU_ADD;
                        isa_pkg::F3_AND: id_next.alu_op = pipe_pkg::ALU_AND;
                        isa_pkg::F3_OR:  id_next.alu_op = pipe_pkg::ALU_OR;
                        isa_pkg::F3_XOR: id_next.alu_op = pipe_pkg::ALU_XOR;
                        isa_pkg::F3_SLT: id_next.alu_op = pipe_pkg::ALU_SLT;
                        default:         id_next.reg_we = 1'b0;
                    endcase
                end
                isa_pkg::OPC_OP_IMM: begin
                    id_next.reg_we  = (funct3 == isa_pkg::F3_ADD);
                    id_next.use_imm = 1'b1;
                    id_next.imm     = {{20{instr[31]}}, instr[31:20]};
                end
                isa_pkg::OPC_LUI: begin
                    id_next.reg_we  = 1'b1;
                    id_next.use_imm = 1'b1;
                    id_next.alu_op  = pipe_pkg::ALU_PASS_B;
                    id_next.imm     = {instr[31:12], 12'b0};
                end
                isa_pkg::OPC_LOAD: begin
                    id_next.is_load = (funct3 == isa_pkg::F3_WORD);
                    id_next.reg_we  = (funct3 == isa_pkg::F3_WORD);
                    id_next.use_imm = 1'b1;
                    id_next.wb_sel  = pipe_pkg::WB_MEM;
                    id_next.imm     = {{20{instr[31]}}, instr[31:20]};
                end
                isa_pkg::OPC_STORE: begin
                    id_next.is_store = (funct3 == isa_pkg::F3_WORD);
                    id_next.use_imm  = 1'b1;
                    id_next.imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                end
                isa_pkg::OPC_BRANCH: begin
                    id_next.is_branch = (funct3 == isa_pkg::F3_BEQ) ||
                                        (funct3 == isa_pkg::F3_BNE);
                    id_next.branch_ne = (funct3 == isa_pkg::F3_BNE);
                    id_next.imm       = {{19{instr[31]}}, instr[31], instr[7],
                                         instr[30:25], instr[11:8], 1'b0};
                end
                isa_pkg::OPC_JAL: begin
                    id_next.is_jal = 1'b1;
                    id_next.reg_we = 1'b1;
                    id_next.wb_sel = pipe_pkg::WB_PC4;
                    id_next.imm    = {{11{instr[31]}}, instr[31], instr[19:12],
                                      instr[20], instr[30:21], 1'b0};
                end
                default: ;
            endcase
        end
    end

    // Bubble on a flush or a load-use stall
    always_ff @(posedge clk) begin
        if (!rst_n || hz.flush_id2exe || hz.stall_front) begin
            id2exe_q <= '0;
        end else begin
            id2exe_q <= id_next;
        end
    end

    assign hz.id_rs1 = rs1;
    assign hz.id_rs2 = rs2;
    assign id2exe_o  = id2exe_q;

endmodule : decode

// File: execute/execute.sv
`timescale 1ns/1ps

module execute (
    input  logic                clk,
    input  logic                rst_n,
    input  pipe_pkg::id2exe_t   id2exe_i,
    input  isa_pkg::word_t      lsu_fwd_i,
    input  pipe_pkg::wrb_t      wrb_i,
    hazard_if.execute_mp        hz,
    output pipe_pkg::redirect_t redirect_o,
    output pipe_pkg::exe2lsu_t  exe2lsu_o
);

    isa_pkg::word_t     rs1_val;
    isa_pkg::word_t     rs2_val;
    isa_pkg::word_t     op_b;
    isa_pkg::word_t     alu_res;
    logic               taken;
    pipe_pkg::exe2lsu_t exe2lsu_q;

    function automatic isa_pkg::word_t fwd_mux(
        input pipe_pkg::fwd_sel_e sel,
        input isa_pkg::word_t     reg_val,
        input isa_pkg::word_t     lsu_val,
        input isa_pkg::word_t     wrb_val
    );
        case (sel)
            pipe_pkg::FWD_LSU: return lsu_val;
            pipe_pkg::FWD_WRB: return wrb_val;
            default:           return reg_val;
        endcase
    endfunction

    assign rs1_val = fwd_mux(hz.fwd_rs1, id2exe_i.rs1_data, lsu_fwd_i, wrb_i.data);
    assign rs2_val = fwd_mux(hz.fwd_rs2, id2exe_i.rs2_data, lsu_fwd_i, wrb_i.data);
    assign op_b    = id2exe_i.use_imm ? id2exe_i.imm : rs2_val;

    always_comb begin
        case (id2exe_i.alu_op)
            pipe_pkg::ALU_SUB:    alu_res = rs1_val - op_b;
            pipe_pkg::ALU_AND:    alu_res = rs1_val & op_b;
            pipe_pkg::ALU_OR:     alu_res = rs1_val | op_b;
            pipe_pkg::ALU_XOR:    alu_res = rs1_val ^ op_b;
            pipe_pkg::ALU_SLT:    alu_res = {{(isa_pkg::XLEN-1){1'b0}},
                                             $signed(rs1_val) < $signed(op_b)};
            pipe_pkg::ALU_PASS_B: alu_res = op_b;
            default:              alu_res = rs1_val + op_b;
        endcase
    end

    // BEQ/BNE compare the register operands, JAL always jumps
    assign taken = id2exe_i.valid &&
                   ((id2exe_i.is_branch && ((rs1_val == rs2_val) ^ id2exe_i.branch_ne)) ||
                    id2exe_i.is_jal);

    assign redirect_o.taken  = taken;
    assign redirect_o.target = id2exe_i.pc + id2exe_i.imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exe2lsu_q <= '0;
        end else begin
            exe2lsu_q.valid      <= id2exe_i.valid;
            exe2lsu_q.rd         <= id2exe_i.rd;
            exe2lsu_q.reg_we     <= id2exe_i.reg_we;
            exe2lsu_q.wb_sel     <= id2exe_i.wb_sel;
            exe2lsu_q.is_load    <= id2exe_i.is_load;
            exe2lsu_q.is_store   <= id2exe_i.is_store;
            exe2lsu_q.alu_result <= alu_res;
            exe2lsu_q.store_data <= rs2_val;
            exe2lsu_q.pc4        <= id2exe_i.pc + 32'd4;
        end
    end

    assign hz.exe_rd      = id2exe_i.rd;
    assign hz.exe_rs1     = id2exe_i.rs1;
    assign hz.exe_rs2     = id2exe_i.rs2;
    assign hz.exe_is_load = id2exe_i.valid && id2exe_i.is_load;
    assign hz.exe_taken   = taken;
    assign exe2lsu_o      = exe2lsu_q;

endmodule : execute

// File: fetch/fetch.sv
`timescale 1ns/1ps

module fetch #(
    parameter isa_pkg::addr_t RESET_PC = '0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  isa_pkg::instr_t     imem_instr_i,
    input  pipe_pkg::redirect_t redirect_i,
    hazard_if.fetch_mp          hz,
    output isa_pkg::addr_t      imem_addr_o,
    output pipe_pkg::if2id_t    if2id_o
);

    isa_pkg::addr_t   pc_q;
    pipe_pkg::if2id_t if2id_q;

    // Redirect wins over a load-use hold
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else if (hz.redirect && redirect_i.taken) begin
            pc_q <= redirect_i.target;
        end else if (!hz.stall_front) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if2id_q.valid <= 1'b0;
            if2id_q.pc    <= RESET_PC;
            if2id_q.instr <= isa_pkg::INSTR_NOP;
        end else if (hz.flush_if2id) begin
            if2id_q.valid <= 1'b0;
            if2id_q.instr <= isa_pkg::INSTR_NOP;
        end else if (!hz.stall_front) begin
            if2id_q.valid <= 1'b1;
            if2id_q.pc    <= pc_q;
            if2id_q.instr <= imem_instr_i;
        end
    end

    assign imem_addr_o = pc_q;
    assign if2id_o     = if2id_q;

endmodule : fetch

// File: project.f
+incdir+tests
common/isa_pkg.sv
common/pipe_pkg.sv
common/hazard_if.sv
fetch/fetch.sv
decode/decode.sv
execute/execute.sv
verilog/lsu.sv
verilog/forward_stall.sv
verilog/pipeline_top.sv
tests/tb_clock.sv
tests/tb_pipeline_top.sv

// File: tests/tb_clock.sv
`timescale 1ns/1ps

// Free-running clock for the testbench
module tb_clock #(
    parameter real PERIOD_NS = 40.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0);
            clk_o = ~clk_o;
        end
    end

endmodule : tb_clock

// File: tests/tb_tests.svh
// RV32I instruction formats
function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] i_type(input logic [31:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm[11:0], rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] b_type(input logic [31:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] addi_instr(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [31:0] imm);
    return i_type(imm, rs1, 3'b000, rd, 7'b0010011);
endfunction

function automatic logic [31:0] alu_instr(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
    return r_type(f7, rs2, rs1, f3, rd);
endfunction

function automatic logic [31:0] lui_instr(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
endfunction

function automatic logic [31:0] lw_instr(input logic [4:0] rd, input logic [4:0] base,
                                         input logic [31:0] offset);
    return i_type(offset, base, 3'b010, rd, 7'b0000011);
endfunction

function automatic logic [31:0] sw_instr(input logic [4:0] src, input logic [4:0] base,
                                         input logic [31:0] offset);
    return {offset[11:5], src, base, 3'b010, offset[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] jal_instr(input logic [4:0] rd, input logic [31:0] offset);
    return {offset[20], offset[10:1], offset[11], offset[19:12], rd, 7'b1101111};
endfunction

function automatic logic [31:0] sign_extend12(input logic [11:0] value);
    return {{20{value[11]}}, value};
endfunction

function automatic logic store_logged(input logic [31:0] addr);
    int i;
    for (i = 0; i < log_addr.size(); i++) begin
        if (log_addr[i] == addr) begin
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

task automatic check_word(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    assert (actual === expected) else
        fail_run($sformatf("CHECK FAILED: %s expected 0x%h actual 0x%h",
                           name, expected, actual));
endtask

task automatic new_program();
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
endtask

task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
endtask

// Program lands at RESET_PC and ends in a jump to itself
task automatic load_program();
    int i;
    int base;
    prog.push_back(jal_instr(5'd0, 32'd0));
    base = RESET_PC[9:2];
    for (i = 0; i < MEM_WORDS; i++) begin
        rom[i] = NOP_INSTR;
    end
    for (i = 0; i < prog.size(); i++) begin
        rom[(base + i) % MEM_WORDS] = prog[i];
    end
endtask

task automatic pulse_reset();
    int i;
    rst_n = 1'b0;
    for (i = 0; i < RESET_CYCLES; i++) begin
        @(negedge clk);
        check_word("dbus_req_o", 32'h0, {31'b0, dbus_req});
    end
    log_addr.delete();
    log_data.delete();
    rst_n = 1'b1;
endtask

task automatic run_program(input logic quiet_bus);
    logic [31:0] final_addr;
    int          i;
    final_addr = exp_addr[exp_addr.size() - 1];
    load_program();
    pulse_reset();
    while (!store_logged(final_addr)) begin
        @(negedge clk);
        // Before the first store the bus must stay idle
        if (quiet_bus && log_addr.size() == 0) begin
            assert (!dbus_req || (dbus_we && dbus_addr == final_addr)) else
                fail_run("Data bus request seen before the first store");
        end
    end
    check_word("store count", exp_addr.size(), log_addr.size());
    for (i = 0; i < exp_addr.size(); i++) begin
        check_word($sformatf("dbus_addr_o (store %0d)", i), exp_addr[i], log_addr[i]);
        check_word($sformatf("dbus_wdata_o (store %0d)", i), exp_data[i], log_data[i]);
    end
endtask

// Writes to x0 are dropped, so the stored word is zero
task automatic reset_store_test();
    new_program();
    prog.push_back(addi_instr(5'd0, 5'd0, 32'h55));
    prog.push_back(addi_instr(5'd0, 5'd0, 32'd0));
    prog.push_back(sw_instr(5'd0, 5'd0, 32'h300));
    expect_store(32'h300, 32'h0);
    run_program(1'b1);
endtask

task automatic alu_chain_test();
    logic [31:0] rnd;
    logic [31:0] v [1:10];
    logic [19:0] imm_u;
    int          r;
    new_program();
    rnd   = $random(seed);
    v[1]  = sign_extend12(rnd[11:0]);
    rnd   = $random(seed);
    v[2]  = v[1] + sign_extend12(rnd[11:0]);
    rnd   = $random(seed);
    imm_u = rnd[19:0];
    v[3]  = v[2] + v[1];
    v[4]  = v[2] - v[3];
    v[5]  = v[4] & v[3];
    v[6]  = v[5] | v[2];
    v[7]  = v[6] ^ v[4];
    v[8]  = ($signed(v[7]) < $signed(v[6])) ? 32'd1 : 32'd0;
    v[9]  = {imm_u, 12'h000};
    v[10] = v[9] + v[8];
    prog.push_back(addi_instr(5'd1, 5'd0, v[1]));
    prog.push_back(addi_instr(5'd2, 5'd1, v[2] - v[1]));
    prog.push_back(alu_instr(7'h00, 3'b000, 5'd3, 5'd2, 5'd1));
    prog.push_back(alu_instr(7'h20, 3'b000, 5'd4, 5'd2, 5'd3));
    prog.push_back(alu_instr(7'h00, 3'b111, 5'd5, 5'd4, 5'd3));
    prog.push_back(alu_instr(7'h00, 3'b110, 5'd6, 5'd5, 5'd2));
    prog.push_back(alu_instr(7'h00, 3'b100, 5'd7, 5'd6, 5'd4));
    prog.push_back(alu_instr(7'h00, 3'b010, 5'd8, 5'd7, 5'd6));
    prog.push_back(lui_instr(5'd9, imm_u));
    prog.push_back(alu_instr(7'h00, 3'b000, 5'd10, 5'd9, 5'd8));
    // Newest result first, so its store data is forwarded
    for (r = 10; r >= 1; r--) begin
        prog.push_back(sw_instr(r[4:0], 5'd0, 32'h200 + 4 * r));
        expect_store(32'h200 + 4 * r, v[r]);
    end
    run_program(1'b0);
endtask

task automatic load_use_test();
    logic [31:0] rnd;
    logic [31:0] a;
    logic [31:0] b;
    new_program();
    rnd = $random(seed);
    a   = sign_extend12(rnd[11:0]);
    rnd = $random(seed);
    b   = sign_extend12(rnd[11:0]);
    prog.push_back(addi_instr(5'd1, 5'd0, a));
    prog.push_back(addi_instr(5'd2, 5'd0, b));
    prog.push_back(sw_instr(5'd1, 5'd0, 32'h240));
    prog.push_back(lw_instr(5'd3, 5'd0, 32'h240));
    prog.push_back(alu_instr(7'h00, 3'b000, 5'd4, 5'd3, 5'd2));
    prog.push_back(sw_instr(5'd4, 5'd0, 32'h244));
    // Loaded value used directly as store data
    prog.push_back(lw_instr(5'd5, 5'd0, 32'h244));
    prog.push_back(sw_instr(5'd5, 5'd0, 32'h248));
    expect_store(32'h240, a);
    expect_store(32'h244, a + b);
    expect_store(32'h248, a + b);
    run_program(1'b0);
endtask

task automatic branch_test();
    new_program();
    prog.push_back(addi_instr(5'd1, 5'd0, 32'd5));
    prog.push_back(addi_instr(5'd2, 5'd0, 32'd5));
    prog.push_back(addi_instr(5'd3, 5'd0, 32'd7));
    // Taken BEQ over two stores
    prog.push_back(b_type(32'd12, 5'd2, 5'd1, 3'b000));
    prog.push_back(sw_instr(5'd1, 5'd0, 32'h280));
    prog.push_back(sw_instr(5'd1, 5'd0, 32'h284));
    prog.push_back(sw_instr(5'd3, 5'd0, 32'h288));
    // Taken BNE over two stores
    prog.push_back(b_type(32'd12, 5'd3, 5'd1, 3'b001));
    prog.push_back(sw_instr(5'd1, 5'd0, 32'h28C));
    prog.push_back(sw_instr(5'd1, 5'd0, 32'h290));
    prog.push_back(sw_instr(5'd2, 5'd0, 32'h294));
    // Not taken, falls through
    prog.push_back(b_type(32'd12, 5'd3, 5'd1, 3'b000));
    prog.push_back(sw_instr(5'd1, 5'd0, 32'h298));
    prog.push_back(sw_instr(5'd3, 5'd0, 32'h29C));
    expect_store(32'h288, 32'd7);
    expect_store(32'h294, 32'd5);
    expect_store(32'h298, 32'd5);
    expect_store(32'h29C, 32'd7);
    run_program(1'b0);
endtask

task automatic jal_test();
    new_program();
    prog.push_back(addi_instr(5'd1, 5'd0, 32'h11));
    // JAL at word 1 skips one store
    prog.push_back(jal_instr(5'd5, 32'd8));
    prog.push_back(sw_instr(5'd1, 5'd0, 32'h2C0));
    prog.push_back(sw_instr(5'd5, 5'd0, 32'h2C4));
    expect_store(32'h2C4, RESET_PC + 32'd4 + 32'd4);
    run_program(1'b0);
endtask

// File: tests/tb_pipeline_top.sv
`timescale 1ns/1ps

module tb_pipeline_top;

    localparam logic [31:0] RESET_PC     = 32'h0000_0100;
    localparam int          MEM_WORDS    = 256;
    localparam int          RESET_CYCLES = 16;
    localparam logic [31:0] NOP_INSTR    = 32'h0000_0013;
    // About twice five tests of 16 reset cycles plus 64 instructions at 3 cycles
    localparam int          TIMEOUT_CYCLES = 2000;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_instr;
    logic        dbus_req;
    logic        dbus_we;
    logic [31:0] dbus_addr;
    logic [31:0] dbus_wdata;
    logic [31:0] dbus_rdata;

    logic [31:0] rom [MEM_WORDS];
    logic [31:0] ram [MEM_WORDS];

    // Every store seen on the data bus, in order
    logic [31:0] log_addr [$];
    logic [31:0] log_data [$];

    // Program and expected stores of the running test
    logic [31:0] prog [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];

    int cycle_count = 0;
    int seed;

    tb_clock #(
        .PERIOD_NS (40.0)
    ) u_tb_clock (
        .clk_o (clk)
    );

    pipeline_top #(
        .RESET_PC (RESET_PC)
    ) u_pipeline_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_instr_i (imem_instr),
        .dbus_rdata_i (dbus_rdata),
        .imem_addr_o  (imem_addr),
        .dbus_req_o   (dbus_req),
        .dbus_we_o    (dbus_we),
        .dbus_addr_o  (dbus_addr),
        .dbus_wdata_o (dbus_wdata)
    );

    // Both memories answer in the same cycle
    assign imem_instr = rom[imem_addr[9:2]];
    assign dbus_rdata = ram[dbus_addr[9:2]];

    always @(posedge clk) begin
        if (dbus_req && dbus_we) begin
            ram[dbus_addr[9:2]] <= dbus_wdata;
            log_addr.push_back(dbus_addr);
            log_data.push_back(dbus_wdata);
        end
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout after %0d cycles, the tests did not finish",
                               cycle_count));
        end
    end

    `include "tb_tests.svh"

    initial begin
        int i;
        seed  = 43099;
        rst_n = 1'b0;
        for (i = 0; i < MEM_WORDS; i++) begin
            rom[i] = NOP_INSTR;
            ram[i] = 32'h5A5A_0000 ^ (i * 4);
        end
        reset_store_test();
        alu_chain_test();
        load_use_test();
        branch_test();
        jal_test();
        $display("sim passed");
        $finish;
    end

endmodule : tb_pipeline_top

// File: verilog/forward_stall.sv
`timescale 1ns/1ps

module forward_stall (
    input  logic  clk,
    input  logic  rst_n,
    hazard_if.fwd hz
);

    logic active_q;
    logic taken;
    logic load_use;

    // Pick the youngest producer, never for x0
    function automatic pipe_pkg::fwd_sel_e fwd_pick(input isa_pkg::reg_idx_t rs);
        if (rs == '0) begin
            return pipe_pkg::FWD_REG;
        end
        if (hz.lsu_we && hz.lsu_rd == rs) begin
            return pipe_pkg::FWD_LSU;
        end
        if (hz.wrb_we && hz.wrb_rd == rs) begin
            return pipe_pkg::FWD_WRB;
        end
        return pipe_pkg::FWD_REG;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_q <= 1'b0;
        end else begin
            active_q <= 1'b1;
        end
    end

    assign taken    = active_q && hz.exe_taken;
    assign load_use = hz.exe_is_load && hz.exe_rd != '0 &&
                      (hz.exe_rd == hz.id_rs1 || hz.exe_rd == hz.id_rs2);

    // Flush takes priority over stall
    assign hz.redirect     = taken;
    assign hz.flush_if2id  = taken;
    assign hz.flush_id2exe = taken;
    assign hz.stall_front  = load_use && !taken;

    // Selects also depend on the LSU and writeback register numbers
    always_comb begin
        hz.fwd_rs1 = fwd_pick(hz.exe_rs1);
        hz.fwd_rs2 = fwd_pick(hz.exe_rs2);
    end

endmodule : forward_stall

// File: verilog/lsu.sv
`timescale 1ns/1ps

module lsu (
    input  logic               clk,
    input  logic               rst_n,
    input  pipe_pkg::exe2lsu_t exe2lsu_i,
    input  isa_pkg::word_t     dbus_rdata_i,
    hazard_if.lsu_mp           hz,
    output logic               dbus_req_o,
    output logic               dbus_we_o,
    output isa_pkg::addr_t     dbus_addr_o,
    output isa_pkg::word_t     dbus_wdata_o,
    output isa_pkg::word_t     lsu_fwd_o,
    output pipe_pkg::wrb_t     wrb_o
);

    isa_pkg::word_t result;
    pipe_pkg::wrb_t wrb_q;

    assign dbus_req_o   = exe2lsu_i.valid && (exe2lsu_i.is_load || exe2lsu_i.is_store);
    assign dbus_we_o    = exe2lsu_i.valid && exe2lsu_i.is_store;
    assign dbus_addr_o  = exe2lsu_i.alu_result;
    assign dbus_wdata_o = exe2lsu_i.store_data;

    always_comb begin
        case (exe2lsu_i.wb_sel)
            pipe_pkg::WB_MEM: result = dbus_rdata_i;
            pipe_pkg::WB_PC4: result = exe2lsu_i.pc4;
            default:          result = exe2lsu_i.alu_result;
        endcase
    end

    // Writeback record
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wrb_q.we <= 1'b0;
        end else begin
            wrb_q.we <= exe2lsu_i.valid && exe2lsu_i.reg_we;
        end
        wrb_q.rd   <= exe2lsu_i.rd;
        wrb_q.data <= result;
    end

    // Load data is not ready for forwarding in this stage
    assign hz.lsu_rd = exe2lsu_i.rd;
    assign hz.lsu_we = exe2lsu_i.valid && exe2lsu_i.reg_we && !exe2lsu_i.is_load;
    assign hz.wrb_rd = wrb_q.rd;
    assign hz.wrb_we = wrb_q.we;

    assign lsu_fwd_o = exe2lsu_i.alu_result;
    assign wrb_o     = wrb_q;

endmodule : lsu

// File: verilog/pipeline_top.sv
`timescale 1ns/1ps

module pipeline_top #(
    parameter isa_pkg::addr_t RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    input  isa_pkg::instr_t imem_instr_i,
    input  isa_pkg::word_t  dbus_rdata_i,
    output isa_pkg::addr_t  imem_addr_o,
    output logic            dbus_req_o,
    output logic            dbus_we_o,
    output isa_pkg::addr_t  dbus_addr_o,
    output isa_pkg::word_t  dbus_wdata_o
);

    pipe_pkg::if2id_t    if2id;
    pipe_pkg::id2exe_t   id2exe;
    pipe_pkg::exe2lsu_t  exe2lsu;
    pipe_pkg::wrb_t      wrb;
    pipe_pkg::redirect_t redirect;
    isa_pkg::word_t      lsu_fwd;

    hazard_if hz_if ();

    fetch #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_instr_i (imem_instr_i),
        .redirect_i   (redirect),
        .hz           (hz_if.fetch_mp),
        .imem_addr_o  (imem_addr_o),
        .if2id_o      (if2id)
    );

    decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .if2id_i  (if2id),
        .wrb_i    (wrb),
        .hz       (hz_if.decode_mp),
        .id2exe_o (id2exe)
    );

    execute u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .id2exe_i   (id2exe),
        .lsu_fwd_i  (lsu_fwd),
        .wrb_i      (wrb),
        .hz         (hz_if.execute_mp),
        .redirect_o (redirect),
        .exe2lsu_o  (exe2lsu)
    );

    lsu u_lsu (
        .clk          (clk),
        .rst_n        (rst_n),
        .exe2lsu_i    (exe2lsu),
        .dbus_rdata_i (dbus_rdata_i),
        .hz           (hz_if.lsu_mp),
        .dbus_req_o   (dbus_req_o),
        .dbus_we_o    (dbus_we_o),
        .dbus_addr_o  (dbus_addr_o),
        .dbus_wdata_o (dbus_wdata_o),
        .lsu_fwd_o    (lsu_fwd),
        .wrb_o        (wrb)
    );

    forward_stall u_forward_stall (
        .clk   (clk),
        .rst_n (rst_n),
        .hz    (hz_if.fwd)
    );

endmodule : pipeline_top
